//--- filelist.f
hw/me_geom_pkg.sv
hw/me_types_pkg.sv
hw/pipe_delay.sv
hw/me_sequencer.sv
hw/pe_array.sv
hw/sad_min_select.sv
hw/me_top.sv
bench/tb_me_asserts.sv
bench/tb_me_top.sv

//--- Makefile
VERILATOR  ?= verilator
TOP        := tb_me_top
RTL_TOP    := me_top
FILELIST   := filelist.f
OBJ_DIR    := obj_dir
LOG        := sim.log
LINT_FLAGS := --lint-only --timing
SIM_FLAGS  := --binary --timing --assert -j 0

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "Regression failed" $(LOG); then exit 1; fi
	@grep -q "Regression passed" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- bench/tb_me_top.sv
`default_nettype none

module tb_me_top
  import me_geom_pkg::*;
  import me_types_pkg::*;
();
  timeunit 1ns;
  timeprecision 1ps;

  localparam int NumTests = 8;
  localparam int DoneLatency = RefPixels * NumCandRows + MemLatency + 2; // start edge to done
  localparam int RunCycles = DoneLatency + 20;
  localparam logic [31:0] LfsrTaps = 32'h80200003; // x^32 + x^22 + x^2 + x + 1
  localparam pixel_t FlatLevel = 8'h5a;

  typedef struct packed {
    offset_t dy;   // planted position
    offset_t dx;
    pixel_t  amp;  // largest noise added to the block
    logic    flat; // constant window and block
    logic    poke; // extra start_i while busy
  } test_entry_t;

  logic                     clk_i;
  logic                     rst_ni;
  logic                     start_i;
  logic                     busy_o;
  logic                     done_o;
  ref_addr_t                ref_addr_o;
  pixel_t                   ref_pixel_i;
  pixel_t                   ref_rd_q;
  search_addr_t [PeNum-1:0] search_addr_o;
  pixel_t       [PeNum-1:0] search_pixel_i;
  pixel_t       [PeNum-1:0] search_rd_q;
  sad_t                     best_sad_o;
  offset_t                  best_dx_o;
  offset_t                  best_dy_o;

  pixel_t      win_mem [SearchSize*SearchSize];
  pixel_t      blk_mem [RefPixels];
  test_entry_t tests   [NumTests];
  logic [31:0] lfsr_q;
  int          errors;
  int          checks;
  int          cur_test;

  me_top dut0 (.*);

  always #50 clk_i = ~clk_i;

  // two read stages, address registered by the DUT
  always @(posedge clk_i) begin
    ref_rd_q    <= blk_mem[ref_addr_o];
    ref_pixel_i <= ref_rd_q;
    for (int k = 0; k < int'(PeNum); k++) begin
      search_rd_q[k]    <= win_mem[search_addr_o[k]];
      search_pixel_i[k] <= search_rd_q[k];
    end
  end

  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ LfsrTaps) : (s >> 1);
  endfunction

  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int b = 0; b < n; b++) begin
      v = {v[30:0], lfsr_q[0]};
      lfsr_q = lfsr_step(lfsr_q); // one step per bit
    end
    return v;
  endfunction

  task automatic fill_images(input test_entry_t e);
    int         idx;
    logic [8:0] v;
    pixel_t     noise;
    for (int i = 0; i < int'(SearchSize * SearchSize); i++) begin
      win_mem[i] = e.flat ? FlatLevel : pixel_t'(rand_bits(8));
    end
    for (int p = 0; p < int'(RefPixels); p++) begin
      idx = (int'(e.dy) + p / int'(RefSize)) * int'(SearchSize) + int'(e.dx) + p % int'(RefSize);
      noise = (e.amp == 8'd0) ? 8'd0 : 8'(rand_bits(8) % (32'(e.amp) + 32'd1));
      v = 9'(win_mem[idx]) + 9'(noise);
      blk_mem[p] = (v > 9'd255) ? 8'hff : v[7:0]; // clip at white
    end
  endtask

  task automatic full_search(output sad_t sad, output offset_t dx, output offset_t dy);
    int best;
    int s;
    int d;
    best = -1;
    for (int y = 0; y < int'(NumCandRows); y++) begin
      for (int x = 0; x < int'(PeNum); x++) begin
        s = 0;
        for (int p = 0; p < int'(RefPixels); p++) begin
          d = int'(win_mem[(y + p / int'(RefSize)) * int'(SearchSize) + x + p % int'(RefSize)]);
          d = d - int'(blk_mem[p]);
          s += (d < 0) ? -d : d;
        end
        if (best < 0 || s < best) begin // scan order keeps lowest dy, then dx
          best = s;
          dx = offset_t'(x);
          dy = offset_t'(y);
        end
      end
    end
    sad = sad_t'(best);
  endtask

  // called a small delay after a rising edge
  task automatic run_search(input logic poke, output int latency, output logic seen);
    start_i = 1'b1;
    @(posedge clk_i);
    #1;
    start_i = 1'b0;
    seen = 1'b0;
    latency = 0;
    while (!seen && latency < RunCycles) begin
      @(posedge clk_i);
      #1;
      latency++;
      start_i = poke && (latency == 40); // ignored while busy
      if (done_o) begin
        seen = 1'b1;
      end else if (!busy_o) begin
        $display("Error: busy_o dropped %0d cycles after start, before done_o (test %0d)",
                 latency, cur_test);
        errors++;
        latency = RunCycles;
      end
    end
    start_i = 1'b0;
  endtask

  task automatic compare_value(input string name, input int got, input int exp);
    checks++;
    if (got != exp) begin
      errors++;
      $display("Error: %s = %h, expected %h (test %0d)", name, got, exp, cur_test);
    end
  endtask

  initial begin
    int      latency;
    logic    seen;
    sad_t    exp_sad;
    offset_t exp_dx;
    offset_t exp_dy;
    clk_i = 1'b0;
    rst_ni = 1'b0;
    start_i = 1'b0;
    ref_pixel_i = '0;
    search_pixel_i = '0;
    lfsr_q = 32'ha257e06a;
    errors = 0;
    checks = 0;
    cur_test = -1;
    tests[0] = '{dy: 3'd3, dx: 3'd5, amp: 8'd0, flat: 1'b0, poke: 1'b0};
    tests[1] = '{dy: 3'd0, dx: 3'd0, amp: 8'd0, flat: 1'b0, poke: 1'b0};
    tests[2] = '{dy: 3'd7, dx: 3'd7, amp: 8'd0, flat: 1'b0, poke: 1'b1};
    tests[3] = '{dy: 3'd2, dx: 3'd6, amp: 8'd4, flat: 1'b0, poke: 1'b0};
    tests[4] = '{dy: 3'd5, dx: 3'd1, amp: 8'd12, flat: 1'b0, poke: 1'b1};
    tests[5] = '{dy: 3'd6, dx: 3'd3, amp: 8'd40, flat: 1'b0, poke: 1'b0};
    tests[6] = '{dy: 3'd4, dx: 3'd2, amp: 8'd0, flat: 1'b1, poke: 1'b0};
    tests[7] = '{dy: 3'd1, dx: 3'd7, amp: 8'd100, flat: 1'b0, poke: 1'b1};
    repeat (4) @(posedge clk_i);
    #1;
    compare_value("busy_o", int'(busy_o), 0);
    compare_value("done_o", int'(done_o), 0);
    compare_value("best_sad_o", int'(best_sad_o), 0);
    compare_value("best_dx_o", int'(best_dx_o), 0);
    compare_value("best_dy_o", int'(best_dy_o), 0);
    compare_value("ref_addr_o", int'(ref_addr_o), 0);
    for (int k = 0; k < int'(PeNum); k++) begin
      compare_value($sformatf("search_addr_o[%0d]", k), int'(search_addr_o[k]), 0);
    end
    rst_ni = 1'b1;
    for (int i = 0; i < NumTests; i++) begin
      cur_test = i;
      fill_images(tests[i]);
      full_search(exp_sad, exp_dx, exp_dy);
      run_search(tests[i].poke, latency, seen);
      if (!seen) begin
        errors++;
        $display("Error: done_o did not rise within %0d cycles of start (test %0d)",
                 RunCycles, i);
      end else begin
        checks++;
        if (latency != DoneLatency) begin
          errors++;
          $display("Error: done_o rose %0d cycles after start instead of %0d (test %0d)",
                   latency, DoneLatency, i);
        end
        if (tests[i].flat) begin // equal SADs everywhere, first candidate wins
          exp_sad = '0;
          exp_dx = '0;
          exp_dy = '0;
        end else if (tests[i].amp == 8'd0) begin
          exp_sad = '0; // exact copy of the planted block
          exp_dx = tests[i].dx;
          exp_dy = tests[i].dy;
        end
        compare_value("best_sad_o", int'(best_sad_o), int'(exp_sad));
        compare_value("best_dx_o", int'(best_dx_o), int'(exp_dx));
        compare_value("best_dy_o", int'(best_dy_o), int'(exp_dy));
      end
    end
    $display("Checks run: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

  initial begin
    #((NumTests * RunCycles + 20) * 100);
    $display("Error: watchdog expired before all searches completed");
    $display("Regression failed");
    $finish;
  end

endmodule

`default_nettype wire

//--- bench/tb_me_asserts.sv
`default_nettype none

module tb_me_asserts
  import me_geom_pkg::*;
  import me_types_pkg::*;
(
  input logic                     clk_i,
  input logic                     rst_ni,
  input logic                     busy_i,
  input logic                     done_i,
  input search_addr_t [PeNum-1:0] search_addr_i
);
  timeunit 1ns;
  timeprecision 1ps;

  function automatic logic addrs_in_window(input search_addr_t [PeNum-1:0] a);
    logic ok;
    ok = 1'b1;
    for (int k = 0; k < int'(PeNum); k++) begin
      if (32'(a[k]) >= SearchSize * SearchSize) begin
        ok = 1'b0;
      end
    end
    return ok;
  endfunction

  done_one_cycle: assert property (@(posedge clk_i) disable iff (!rst_ni)
    done_i |=> !done_i) else $error("done_o lasted more than one cycle");

  done_ends_busy: assert property (@(posedge clk_i) disable iff (!rst_ni)
    done_i |-> (!busy_i && $past(busy_i))) else $error("done_o without busy_o falling");

  busy_ends_on_done: assert property (@(posedge clk_i) disable iff (!rst_ni)
    $fell(busy_i) |-> done_i) else $error("busy_o fell without done_o");

  addr_in_window: assert property (@(posedge clk_i) disable iff (!rst_ni)
    busy_i |-> addrs_in_window(search_addr_i)) else $error("search address outside the window");

endmodule

bind me_top tb_me_asserts u_asserts (
  .clk_i         (clk_i),
  .rst_ni        (rst_ni),
  .busy_i        (busy_o),
  .done_i        (done_o),
  .search_addr_i (search_addr_o)
);

`default_nettype wire

//--- hw/me_top.sv
`default_nettype none

module me_top
  import me_geom_pkg::*;
  import me_types_pkg::*;
(
  input  logic                     clk_i,
  input  logic                     rst_ni,
  input  logic                     start_i,
  output logic                     busy_o,
  output logic                     done_o,
  output ref_addr_t                ref_addr_o,
  input  pixel_t                   ref_pixel_i,
  output search_addr_t [PeNum-1:0] search_addr_o,
  input  pixel_t       [PeNum-1:0] search_pixel_i,
  output sad_t                     best_sad_o,
  output offset_t                  best_dx_o,
  output offset_t                  best_dy_o
);

  logic             start_search;
  pe_ctrl_t         seq_ctrl;
  pe_ctrl_t         pe_ctrl;      // aligned with the read data
  offset_t          seq_row;
  offset_t          pix_row;
  sad_t [PeNum-1:0] row_sums;
  logic             row_valid;

  me_sequencer u_seq (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .start_i        (start_i),
    .done_i         (done_o),
    .busy_o         (busy_o),
    .start_search_o (start_search),
    .ref_addr_o     (ref_addr_o),
    .search_addr_o  (search_addr_o),
    .ctrl_o         (seq_ctrl),
    .cand_row_o     (seq_row)
  );

  pipe_delay #(.T(pe_ctrl_t), .Depth(MemLatency)) u_ctrl_dly (
    .clk_i  (clk_i),
    .rst_ni (rst_ni),
    .d_i    (seq_ctrl),
    .q_o    (pe_ctrl)
  );

  pipe_delay #(.T(offset_t), .Depth(MemLatency)) u_row_dly (
    .clk_i  (clk_i),
    .rst_ni (rst_ni),
    .d_i    (seq_row),
    .q_o    (pix_row)
  );

  pe_array u_pe (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .ctrl_i         (pe_ctrl),
    .ref_pixel_i    (ref_pixel_i),
    .search_pixel_i (search_pixel_i),
    .sums_o         (row_sums),
    .row_valid_o    (row_valid)
  );

  sad_min_select u_sel (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .start_search_i (start_search),
    .row_valid_i    (row_valid),
    .sums_i         (row_sums),
    .cand_row_i     (pix_row),
    .best_sad_o     (best_sad_o),
    .best_dx_o      (best_dx_o),
    .best_dy_o      (best_dy_o),
    .done_o         (done_o)
  );

endmodule

`default_nettype wire

//--- hw/sad_min_select.sv
`default_nettype none

module sad_min_select
  import me_geom_pkg::*;
  import me_types_pkg::*;
(
  input  logic             clk_i,
  input  logic             rst_ni,
  input  logic             start_search_i,
  input  logic             row_valid_i,
  input  sad_t [PeNum-1:0] sums_i,
  input  offset_t          cand_row_i,
  output sad_t             best_sad_o,
  output offset_t          best_dx_o,
  output offset_t          best_dy_o,
  output logic             done_o
);

  sad_t    node_sad [2*PeNum-1]; // heap order, leaves at PeNum-1 and up
  offset_t node_dx  [2*PeNum-1];
  offset_t cand_row_q;           // matches the PE output register
  logic    first_row_q;
  logic    take_row;

  // comparator tree, left child wins a tie so the lower dx is kept
  always_comb begin
    for (int k = 0; k < PeNum; k++) begin
      node_sad[PeNum-1+k] = sums_i[k];
      node_dx[PeNum-1+k]  = offset_t'(k);
    end
    for (int n = PeNum - 2; n >= 0; n--) begin
      if (node_sad[2*n+2] < node_sad[2*n+1]) begin
        node_sad[n] = node_sad[2*n+2];
        node_dx[n]  = node_dx[2*n+2];
      end else begin
        node_sad[n] = node_sad[2*n+1];
        node_dx[n]  = node_dx[2*n+1];
      end
    end
  end

  // strictly smaller only, earlier rows keep ties
  assign take_row = row_valid_i & (first_row_q | (node_sad[0] < best_sad_o));

  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      best_sad_o  <= '0;
      best_dx_o   <= '0;
      best_dy_o   <= '0;
      done_o      <= 1'b0;
      first_row_q <= 1'b0;
      cand_row_q  <= '0;
    end else begin
      cand_row_q <= cand_row_i;
      done_o     <= row_valid_i & (cand_row_q == offset_t'(NumCandRows - 1));
      if (take_row) begin
        best_sad_o <= node_sad[0];
        best_dx_o  <= node_dx[0];
        best_dy_o  <= cand_row_q;
      end
      if (row_valid_i) begin
        first_row_q <= 1'b0;
      end
      if (start_search_i) begin
        first_row_q <= 1'b1; // next row loads unconditionally
      end
    end
  end

endmodule

`default_nettype wire

//--- hw/pe_array.sv
`default_nettype none

module pe_array
  import me_geom_pkg::*;
  import me_types_pkg::*;
(
  input  logic               clk_i,
  input  logic               rst_ni,
  input  pe_ctrl_t           ctrl_i,
  input  pixel_t             ref_pixel_i,
  input  pixel_t [PeNum-1:0] search_pixel_i,
  output sad_t   [PeNum-1:0] sums_o,
  output logic               row_valid_o
);

  pixel_t [PeNum-1:0] abs_diff;
  sad_t   [PeNum-1:0] acc_q;
  sad_t   [PeNum-1:0] acc_next;

  always_comb begin
    for (int k = 0; k < PeNum; k++) begin
      abs_diff[k] = (search_pixel_i[k] > ref_pixel_i) ? search_pixel_i[k] - ref_pixel_i
                                                       : ref_pixel_i - search_pixel_i[k];
      acc_next[k] = ctrl_i.first ? sad_t'(abs_diff[k])
                                 : acc_q[k] + sad_t'(abs_diff[k]);
    end
  end

  always_ff @(posedge clk_i) begin
    acc_q <= acc_next;
    if (ctrl_i.last) begin
      sums_o <= acc_next; // accumulators are free for the next row
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      row_valid_o <= 1'b0;
    end else begin
      row_valid_o <= ctrl_i.last;
    end
  end

endmodule

`default_nettype wire

//--- hw/me_sequencer.sv
`default_nettype none

module me_sequencer
  import me_geom_pkg::*;
  import me_types_pkg::*;
(
  input  logic                       clk_i,
  input  logic                       rst_ni,
  input  logic                       start_i,
  input  logic                       done_i,
  output logic                       busy_o,
  output logic                       start_search_o,
  output ref_addr_t                  ref_addr_o,
  output search_addr_t [PeNum-1:0]   search_addr_o,
  output pe_ctrl_t                   ctrl_o,
  output offset_t                    cand_row_o
);

  logic                     busy_q;
  logic                     active_q;   // address issue phase
  ref_addr_t                ref_cnt_q;
  offset_t                  row_cnt_q;
  logic                     accept;
  logic                     last_pix;
  logic                     last_row;
  search_addr_t             win_row;
  search_addr_t             win_base;
  search_addr_t [PeNum-1:0] search_addr;

  assign busy_o   = busy_q & ~done_i; // drops together with the done pulse
  assign accept   = start_i & ~busy_o;
  assign last_pix = (ref_cnt_q == ref_addr_t'(RefPixels - 1));
  assign last_row = (row_cnt_q == offset_t'(NumCandRows - 1));

  // window pixel under reference pixel (r, c) for candidate (dy, dx = k)
  always_comb begin
    win_row  = search_addr_t'(row_cnt_q) + search_addr_t'(ref_cnt_q / RefSize);
    win_base = win_row * search_addr_t'(SearchSize) + search_addr_t'(ref_cnt_q % RefSize);
    for (int k = 0; k < PeNum; k++) begin
      search_addr[k] = win_base + search_addr_t'(k); // PE k sits k columns right
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      busy_q         <= 1'b0;
      active_q       <= 1'b0;
      start_search_o <= 1'b0;
      ref_cnt_q      <= '0;
      row_cnt_q      <= '0;
    end else begin
      start_search_o <= accept;
      if (accept) begin
        busy_q    <= 1'b1;
        active_q  <= 1'b1;
        ref_cnt_q <= '0;
        row_cnt_q <= '0;
      end else begin
        if (done_i) begin
          busy_q <= 1'b0;
        end
        if (active_q) begin
          ref_cnt_q <= last_pix ? '0 : ref_cnt_q + 1'b1;
          if (last_pix) begin
            row_cnt_q <= row_cnt_q + 1'b1;
            active_q  <= ~last_row; // whole window issued
          end
        end
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      ref_addr_o    <= '0;
      search_addr_o <= '0;
      ctrl_o        <= '0;
      cand_row_o    <= '0;
    end else if (active_q) begin
      ref_addr_o    <= ref_cnt_q;
      search_addr_o <= search_addr;
      ctrl_o.first  <= (ref_cnt_q == '0);
      ctrl_o.last   <= last_pix;
      cand_row_o    <= row_cnt_q;
    end else begin
      ref_addr_o    <= '0;
      search_addr_o <= '0;
      ctrl_o        <= '0; // no flags between runs
    end
  end

endmodule

`default_nettype wire

//--- hw/pipe_delay.sv
`default_nettype none

module pipe_delay #(
  parameter type         T     = logic,
  parameter int unsigned Depth = 2
) (
  input  logic clk_i,
  input  logic rst_ni,
  input  T     d_i,
  output T     q_o
);

  T stage_q [Depth];

  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      for (int i = 0; i < Depth; i++) begin
        stage_q[i] <= '0;
      end
    end else begin
      stage_q[0] <= d_i;
      for (int i = 1; i < Depth; i++) begin
        stage_q[i] <= stage_q[i-1]; // shift one stage per clock
      end
    end
  end

  assign q_o = stage_q[Depth-1];

endmodule

`default_nettype wire

//--- hw/me_types_pkg.sv
`default_nettype none

package me_types_pkg;

  import me_geom_pkg::*;

  typedef logic [7:0] pixel_t; // unsigned luma sample

  typedef logic [$clog2(RefPixels)-1:0] ref_addr_t; // row-major in the block

  // row * SearchSize + column
  typedef logic [$clog2(SearchSize * SearchSize)-1:0] search_addr_t;

  typedef logic [$clog2(RefPixels * 255 + 1)-1:0] sad_t; // holds 16 * 255

  typedef logic [$clog2(PeNum)-1:0] offset_t; // dx and dy

  typedef struct packed {
    logic first; // load the difference, do not accumulate
    logic last;  // pixel closes a candidate row
  } pe_ctrl_t;

endpackage

`default_nettype wire

//--- hw/me_geom_pkg.sv
`default_nettype none

package me_geom_pkg;

  // reference block edge in pixels
  localparam int unsigned RefSize = 4;

  // search window edge in pixels
  localparam int unsigned SearchSize = 11;

  localparam int unsigned PeNum = SearchSize - RefSize + 1; // one PE per candidate column
  localparam int unsigned NumCandRows = SearchSize - RefSize + 1;
  localparam int unsigned RefPixels = RefSize * RefSize; // pixels per candidate

  // registered address to read data at the memory outputs
  localparam int unsigned MemLatency = 2;

endpackage

`default_nettype wire
